// ==== build.f ====
+incdir+hdl
+incdir+sim
hdl/video_pkg.sv
hdl/tile_pkg.sv
hdl/tile_ram.sv
hdl/tile_fetch.sv
hdl/pixel_shifter.sv
hdl/palette_lut.sv
hdl/scroll_layer.sv
sim/scroll_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f build.f --top-module scroll_tb -o scroll_sim; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/scroll_sim)
status=$?
printf '%s\n' "$out"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "PASS: all tests"; then
    exit 0
fi
exit 1

// ==== sim/scroll_tests.svh ====
// Directed tests for the scroll tile layer, included into the testbench top
// Each task drives the DUT and checks it against the testbench images

// Returns just after a pixel edge, DUT beam is hdump minus one
task automatic wait_pixel();
    @(negedge clk);
    while (pxl_cen) begin
        @(negedge clk);
    end
endtask

task automatic cpu_write(input logic [11:0] a, input logic [7:0] d);
    @(posedge clk);
    cpu_addr <= a;
    cpu_dout <= d;
    cpu_rnw  <= 1'b0;
    vram_cs  <= 1'b1;
    vram_img[a] = d;
endtask

task automatic cpu_release();
    @(posedge clk);
    cpu_rnw <= 1'b1;
    vram_cs <= 1'b0;
endtask

// Readback is due one clock after the address
task automatic cpu_read_check(input logic [11:0] a);
    @(posedge clk);
    cpu_addr <= a;
    cpu_rnw  <= 1'b1;
    vram_cs  <= 1'b1;
    @(posedge clk);
    vram_cs <= 1'b0;
    @(negedge clk);
    expect_equal("vram_dout", 32'(vram_dout), 32'(vram_img[a]));
endtask

task automatic fill_codes();
    logic [31:0] rnd;
    for (int a = 0; a < 2048; a++) begin
        rnd = $random(seed);
        cpu_write(12'(a), rnd[7:0]);
    end
    cpu_release();
endtask

// Same attribute byte in every slot
task automatic fill_attrs(input logic [7:0] attr);
    for (int a = 2048; a < 4096; a++) begin
        cpu_write(12'(a), attr);
    end
    cpu_release();
    cur_attr = attr;
endtask

task automatic set_scroll(input logic [7:0] s);
    @(posedge clk);
    scr_din <= s;
    scr_we  <= 1'b1;
    @(posedge clk);
    scr_we <= 1'b0;
    scroll = s;
endtask

// Board plane order, nibble k of a half is bits k+8, k+12, k, k+4
function automatic logic [3:0] tile_nibble(input logic [31:0] w, input logic [2:0] n);
    logic [15:0] half;
    logic [1:0]  k;
    half = n[2] ? w[31:16] : w[15:0];
    k    = n[1:0];
    return {half[8 + k], half[12 + k], half[k], half[4 + k]};
endfunction

// Checks ROM address and all eight pixels of every other tile slot
task automatic check_tiles(input int n);
    logic [8:0]  h;
    logic [7:0]  colh;
    logic [7:0]  col;
    logic [7:0]  row;
    logic [13:0] exp_addr;
    logic [31:0] word;
    logic        mirror;
    logic [2:0]  nib;
    repeat (16) wait_pixel();
    for (int t = 0; t < n; t++) begin
        // Slot phase 0, rom_addr just changed
        // Line start skipped since the VRAM row is still the old line's
        do begin
            wait_pixel();
            h = hdump - 9'd1;
        end while (h[2:0] != 3'd0 || h == 9'd0);
        colh = flip ? (~h[7:0] - 8'd3) : h[7:0];
        col  = colh + scroll + 8'd1;
        row  = flip ? ~vdump : vdump;
        exp_addr = {cur_attr[6:5], cur_attr[7],
                    vram_img[{1'b0, row[7:3], 1'b0, col[7:3]}], row[2:0]};
        expect_equal("rom_addr", 32'(rom_addr), 32'(exp_addr));
        word   = rom_word(exp_addr);
        mirror = cur_attr[4] ^ flip;
        // First pixel reaches pxl six pixel edges after phase 0
        repeat (6) wait_pixel();
        for (int k = 0; k < 8; k++) begin
            nib = mirror ? 3'(k) : 3'(7 - k);
            expect_equal("pxl", 32'(pxl), 32'(pal_img[{cur_attr[3:0], tile_nibble(word, nib)}]));
            if (k < 7) begin
                wait_pixel();
            end
        end
    end
endtask

task automatic test_vram_readback();
    logic [11:0] addrs [64];
    logic [31:0] rnd;
    for (int i = 0; i < 64; i++) begin
        rnd      = $random(seed);
        addrs[i] = rnd[11:0];
        cpu_write(addrs[i], rnd[23:16]);
    end
    // Same offset in both banks
    cpu_write(12'h2a5, 8'h3c);
    cpu_write(12'haa5, 8'hc3);
    cpu_release();
    for (int i = 0; i < 64; i++) begin
        cpu_read_check(addrs[i]);
    end
    cpu_read_check(12'h2a5);
    cpu_read_check(12'haa5);
endtask

task automatic test_tiles_plain();
    for (int i = 0; i < 256; i++) begin
        pal_img[i] = 4'(i * 7 + i / 16 * 3 + 5);
        @(posedge clk);
        prog_addr <= 8'(i);
        prog_data <= pal_img[i];
        prog_en   <= 1'b1;
    end
    @(posedge clk);
    prog_en <= 1'b0;
    fill_codes();
    fill_attrs(8'b101_0_0011);
    check_tiles(12);
endtask

task automatic test_tiles_hflip();
    fill_attrs(8'b011_1_0011);
    check_tiles(12);
    // Other palette
    fill_attrs(8'b110_1_1010);
    check_tiles(12);
endtask

task automatic test_scroll();
    logic [31:0] rnd;
    fill_attrs(8'b100_0_0110);
    set_scroll(8'd37);
    check_tiles(16);
    rnd = $random(seed);
    set_scroll(rnd[7:0]);
    check_tiles(16);
endtask

task automatic test_flip();
    @(posedge clk);
    flip <= 1'b1;
    check_tiles(16);
    set_scroll(8'd93);
    check_tiles(16);
endtask

// ==== sim/scroll_tb.sv ====
// Testbench top for the scroll tile layer
// Runs the raster and ROM model, then the included directed tests
`timescale 1ns/1ns
`include "scroll_settings.svh"

module scroll_tb;

    import video_pkg::*;

    localparam int CLK_NS      = 10;
    localparam int FRAME_NS    = 512 * 256 * 2 * CLK_NS;
    localparam int N_TESTS     = 5;
    localparam int WATCHDOG_NS = 2 * N_TESTS * FRAME_NS;

    logic                      clk;
    logic                      rst;
    logic                      pxl_cen = 1'b0;
    logic [8:0]                hdump = '0;
    logic [7:0]                vdump = '0;
    logic                      flip;
    beam_t                     beam;
    logic [11:0]               cpu_addr;
    logic [7:0]                cpu_dout;
    logic                      cpu_rnw;
    logic                      vram_cs;
    logic [7:0]                vram_dout;
    logic [7:0]                scr_din;
    logic                      scr_we;
    logic [`SCROLL_PAL_AW-1:0] prog_addr;
    logic [3:0]                prog_data;
    logic                      prog_en;
    logic [13:0]               rom_addr;
    logic [`SCROLL_ROM_DW-1:0] rom_data;
    logic                      rom_ok;
    logic [3:0]                pxl;

    // Expected contents of both VRAM banks and the palette
    logic [7:0] vram_img [4096];
    logic [3:0] pal_img [256];
    logic [7:0] scroll;
    logic [7:0] cur_attr;
    integer     seed = 1762;
    int         checks = 0;
    int         errors = 0;

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // Free-running raster, one pixel every other clock
    always @(posedge clk) begin
        pxl_cen <= ~pxl_cen;
        if (pxl_cen) begin
            hdump <= hdump + 9'd1;
            if (hdump == 9'd511) begin
                vdump <= vdump + 8'd1;
            end
        end
    end

    assign beam = {hdump, vdump, flip};

    // Graphics ROM, address twice with each nibble XORed by its position
    function automatic logic [31:0] rom_word(input logic [13:0] a);
        return {2'b00, a, 2'b00, a} ^ 32'h7654_3210;
    endfunction

    assign rom_data = rom_word(rom_addr);
    assign rom_ok   = 1'b1;

    scroll_layer UUT (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .beam(beam),
        .cpu_addr(cpu_addr), .cpu_dout(cpu_dout), .cpu_rnw(cpu_rnw), .vram_cs(vram_cs),
        .vram_dout(vram_dout), .scr_din(scr_din), .scr_we(scr_we),
        .prog_addr(prog_addr), .prog_data(prog_data), .prog_en(prog_en),
        .rom_addr(rom_addr), .rom_data(rom_data), .rom_ok(rom_ok), .pxl(pxl)
    );

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    `include "scroll_tests.svh"

    initial begin
        rst       = 1'b1;
        flip      = 1'b0;
        cpu_addr  = '0;
        cpu_dout  = '0;
        cpu_rnw   = 1'b1;
        vram_cs   = 1'b0;
        scr_din   = '0;
        scr_we    = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        prog_en   = 1'b0;
        scroll    = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        repeat (4) @(posedge clk);
        test_vram_readback();
        test_tiles_plain();
        test_tiles_hflip();
        test_scroll();
        test_flip();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Hang guard, twice the frame time of all tests
    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: tests still running at %0t ns", $time);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// ==== hdl/scroll_layer.sv ====
// Scrolling background tile layer, top level
// CPU VRAM access, row scroll register, fetch, shift and palette stages
`timescale 1ns/1ns
`include "scroll_settings.svh"

module scroll_layer (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      pxl_cen,
    input  video_pkg::beam_t          beam,
    input  logic [11:0]               cpu_addr,
    input  logic [7:0]                cpu_dout,
    input  logic                      cpu_rnw,
    input  logic                      vram_cs,
    output logic [7:0]                vram_dout,
    input  logic [7:0]                scr_din,
    input  logic                      scr_we,
    input  logic [`SCROLL_PAL_AW-1:0] prog_addr,
    input  logic [3:0]                prog_data,
    input  logic                      prog_en,
    output logic [13:0]               rom_addr,
    input  logic [`SCROLL_ROM_DW-1:0] rom_data,
    input  logic                      rom_ok,
    output logic [3:0]                pxl
);

    import tile_pkg::*;

    logic                      vram_we;
    logic                      we_code;
    logic                      we_attr;
    logic                      bank_q;
    logic [7:0]                hpos;
    logic [`SCROLL_VRAM_AW-1:0] vid_addr;
    vram_word_t                code_cpu;
    vram_word_t                code_vid;
    tile_attr_t                attr_cpu;
    tile_attr_t                attr_vid;
    row_req_t                  req;
    logic [`SCROLL_PAL_AW-1:0] pal_addr;

    // Bank select is cpu_addr[11], low bank holds codes
    assign vram_we = vram_cs & ~cpu_rnw;
    assign we_code = vram_we & ~cpu_addr[11];
    assign we_attr = vram_we &  cpu_addr[11];

    // Readback follows the RAM latency
    always_ff @(posedge clk) bank_q <= cpu_addr[11];
    assign vram_dout = bank_q ? vram_word_t'(attr_cpu) : code_cpu;

    // Row scroll register
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            hpos <= '0;
        end else if (scr_we) begin
            hpos <= scr_din;
        end
    end

    tile_ram #(.payload_t(vram_word_t)) u_code (
        .clk(clk), .cpu_addr(cpu_addr[10:0]), .cpu_we(we_code), .cpu_din(cpu_dout),
        .cpu_q(code_cpu), .vid_addr(vid_addr), .vid_q(code_vid)
    );

    tile_ram #(.payload_t(tile_attr_t)) u_attr (
        .clk(clk), .cpu_addr(cpu_addr[10:0]), .cpu_we(we_attr), .cpu_din(cpu_dout),
        .cpu_q(attr_cpu), .vid_addr(vid_addr), .vid_q(attr_vid)
    );

    tile_fetch u_fetch (
        .clk(clk), .rst(rst), .pxl_cen(pxl_cen), .beam(beam), .hscroll(hpos),
        .vid_addr(vid_addr), .code(code_vid), .attr(attr_vid),
        .rom_addr(rom_addr), .req(req)
    );

    pixel_shifter u_shift (
        .clk(clk), .pxl_cen(pxl_cen), .req(req), .rom_data(rom_data), .pal_addr(pal_addr)
    );

    palette_lut u_pal (
        .clk(clk), .pxl_cen(pxl_cen), .prog_addr(prog_addr), .prog_data(prog_data),
        .prog_en(prog_en), .rd_addr(pal_addr), .pxl(pxl)
    );

    // ROM data must be ready when the shifter captures it
    a_rom_ready: assert property (
        @(posedge clk) disable iff (rst) (pxl_cen && req.load) |-> rom_ok
    ) else $error("scroll_layer: ROM data not ready at tile load");

endmodule

// ==== hdl/palette_lut.sv ====
// Result stage of the scroll layer
// Palette PROM, loaded through the programming port, read once per pixel
`timescale 1ns/1ns
`include "scroll_settings.svh"

module palette_lut (
    input  logic                      clk,
    input  logic                      pxl_cen,
    input  logic [`SCROLL_PAL_AW-1:0] prog_addr,
    input  logic [3:0]                prog_data,
    input  logic                      prog_en,
    input  logic [`SCROLL_PAL_AW-1:0] rd_addr,
    output logic [3:0]                pxl
);

    logic [3:0] mem [2**`SCROLL_PAL_AW];

    // Programming port, any time
    always_ff @(posedge clk) begin
        if (prog_en) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // Colour index out, one per pixel
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pxl <= mem[rd_addr];
        end
    end

    // Program enable must stay known once driven
    a_prog_known: assert property (
        @(posedge clk) !$isunknown($past(prog_en)) |-> !$isunknown(prog_en)
    ) else $error("palette_lut: prog_en went unknown");

endmodule

// ==== hdl/pixel_shifter.sv ====
// Execute stage of the scroll layer
// Reorders the ROM word into pixels and shifts them out, mirrored or not
`timescale 1ns/1ns
`include "scroll_settings.svh"

module pixel_shifter (
    input  logic                      clk,
    input  logic                      pxl_cen,
    input  tile_pkg::row_req_t        req,
    input  logic [`SCROLL_ROM_DW-1:0] rom_data,
    output logic [`SCROLL_PAL_AW-1:0] pal_addr
);

    localparam int NIBS  = `SCROLL_TILE_W;
    localparam int NIB_W = `SCROLL_ROM_DW / `SCROLL_TILE_W;

    logic [`SCROLL_ROM_DW-1:0] reordered;
    logic [`SCROLL_ROM_DW-1:0] pxl_data;
    logic [3:0]                cur_pal;
    logic                      cur_mirror;

    // Board plane interleave
    // Upper four nibbles come from ROM bits 31..16, lower four from 15..0
    // Within a half, nibble k takes bits k+8, k+12, k, k+4 from MSB down
    always_comb begin
        int base;
        int k;
        reordered = '0;
        for (int n = 0; n < NIBS; n++) begin
            base = (n / 4) * 16;
            k    = n % 4;
            reordered[n*NIB_W+3] = rom_data[base+8+k];
            reordered[n*NIB_W+2] = rom_data[base+12+k];
            reordered[n*NIB_W+1] = rom_data[base+k];
            reordered[n*NIB_W+0] = rom_data[base+4+k];
        end
    end

    // New tile on load, otherwise one nibble per pixel
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (req.load) begin
                pxl_data   <= reordered;
                cur_pal    <= req.pal;
                cur_mirror <= req.mirror;
            end else if (cur_mirror) begin
                pxl_data <= pxl_data >> NIB_W;
            end else begin
                pxl_data <= pxl_data << NIB_W;
            end
        end
    end

    // Mirrored tiles drain from the bottom nibble
    assign pal_addr = {cur_pal, cur_mirror ? pxl_data[NIB_W-1:0]
                                           : pxl_data[`SCROLL_ROM_DW-1 -: NIB_W]};

endmodule

// ==== hdl/tile_fetch.sv ====
// Decode stage of the scroll layer
// Forms the scrolled VRAM address, decodes the attribute, drives the ROM address
`timescale 1ns/1ns
`include "scroll_settings.svh"

module tile_fetch (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pxl_cen,
    input  video_pkg::beam_t           beam,
    input  logic [7:0]                 hscroll,
    output logic [`SCROLL_VRAM_AW-1:0] vid_addr,
    input  tile_pkg::vram_word_t       code,
    input  tile_pkg::tile_attr_t       attr,
    output logic [13:0]                rom_addr,
    output tile_pkg::row_req_t         req
);

    import video_pkg::*;
    import tile_pkg::*;

    logic [7:0] hdf;
    logic [7:0] heff;
    logic [7:0] vf;
    logic       load_q;
    logic [3:0] pal_q;
    logic       mirror_q;

    // Scrolled column, one ahead of the beam
    assign hdf  = col_of(beam);
    assign heff = hdf + hscroll + 8'd1;

    // 5 row bits, unused bit, 5 column bits
    assign vid_addr = {vf[7:3], 1'b0, heff[7:3]};

    // Line latch, flipped with the screen
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            vf <= '0;
        end else begin
            vf <= row_of(beam);
        end
    end

    // Load strobe lasts one pixel so the shifter sees it on the next pxl_cen
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            load_q <= 1'b0;
        end else if (pxl_cen) begin
            load_q <= beam.hdump[2:0] == 3'd4;
        end
    end

    // Slot phase 0 picks the ROM row, phase 4 latches palette and mirror
    always_ff @(posedge clk) begin
        if (pxl_cen && beam.hdump[2:0] == 3'd0) begin
            rom_addr <= {code_msb_of(attr), code, vf[2:0]};
        end
        if (pxl_cen && beam.hdump[2:0] == 3'd4) begin
            pal_q    <= attr.pal;
            mirror_q <= mirror_of(attr, beam.flip);
        end
    end

    assign req = '{pal: pal_q, mirror: mirror_q, load: load_q};

    // Load rises on a one-clock pixel strobe, so the shifter takes it once
    a_load_on_cen: assert property (
        @(posedge clk) disable iff (rst) $rose(req.load) |-> $past(pxl_cen) && !pxl_cen
    ) else $error("tile_fetch: load rose without a one-clock pxl_cen");

endmodule

// ==== hdl/tile_ram.sv ====
// Dual-port video RAM bank, CPU port plus video read port
// One instance per bank, payload type picks code or attribute view
`timescale 1ns/1ns
`include "scroll_settings.svh"

module tile_ram #(
    parameter type payload_t = tile_pkg::vram_word_t
) (
    input  logic                       clk,
    input  logic [`SCROLL_VRAM_AW-1:0] cpu_addr,
    input  logic                       cpu_we,
    input  tile_pkg::vram_word_t       cpu_din,
    output payload_t                   cpu_q,
    input  logic [`SCROLL_VRAM_AW-1:0] vid_addr,
    output payload_t                   vid_q
);

    payload_t mem [2**`SCROLL_VRAM_AW];

    // CPU side, write and read share the address
    always_ff @(posedge clk) begin
        if (cpu_we) begin
            mem[cpu_addr] <= payload_t'(cpu_din);
        end
        cpu_q <= mem[cpu_addr];
    end

    // Video side is read only
    always_ff @(posedge clk) begin
        vid_q <= mem[vid_addr];
    end

    // Once the write enable is driven it must stay driven
    a_we_known: assert property (
        @(posedge clk) !$isunknown($past(cpu_we)) |-> !$isunknown(cpu_we)
    ) else $error("tile_ram: cpu_we went unknown");

endmodule

// ==== hdl/tile_pkg.sv ====
// Tile data types shared by the VRAM, fetch and pixel stages
// Attribute layout follows the board's attribute RAM byte
package tile_pkg;

    // One byte of the code bank
    typedef logic [7:0] vram_word_t;

    // Attribute byte as stored in RAM
    // code_msb holds raw bits 7..5, decoded as {bit6, bit5, bit7}
    typedef struct packed {
        logic [2:0] code_msb;
        logic       hflip;
        logic [3:0] pal;
    } tile_attr_t;

    // Handed from fetch to shifter once per tile
    // mirror already folds in the screen flip
    typedef struct packed {
        logic [3:0] pal;
        logic       mirror;
        logic       load;
    } row_req_t;

    // Tile code MSBs in ROM address order
    function automatic logic [2:0] code_msb_of(tile_attr_t a);
        return {a.code_msb[1:0], a.code_msb[2]};
    endfunction

    // Mirror sense for the current tile
    function automatic logic mirror_of(tile_attr_t a, logic flip);
        return a.hflip ^ flip;
    endfunction

endpackage

// ==== hdl/video_pkg.sv ====
// Raster timing types for the video layers
// Beam position and screen flip, plus helpers for the flipped coordinates
package video_pkg;

    // Beam position as delivered by the timing generator
    typedef struct packed {
        logic [8:0] hdump;
        logic [7:0] vdump;
        logic       flip;
    } beam_t;

    // Horizontal position seen by the tile map
    // Flipped screen runs backwards, offset by 3 to line up with the fetch
    function automatic logic [7:0] col_of(beam_t b);
        logic [7:0] h;
        h = b.hdump[7:0];
        return b.flip ? (~h - 8'd3) : h;
    endfunction

    // Line as seen by the tile map, inverted under flip
    function automatic logic [7:0] row_of(beam_t b);
        return {8{b.flip}} ^ b.vdump;
    endfunction

endpackage

// ==== hdl/scroll_settings.svh ====
// Sizes shared by the scroll tile layer
// Include wherever a width of the VRAM, palette or graphics ROM is needed
`ifndef SCROLL_SETTINGS_SVH
`define SCROLL_SETTINGS_SVH

// VRAM bank address, 2 KB per bank
`define SCROLL_VRAM_AW 11

// Palette PROM address, pal nibble plus pixel nibble
`define SCROLL_PAL_AW 8

// Pixels in one tile row and the ROM word that carries them
`define SCROLL_TILE_W 8
`define SCROLL_ROM_DW 32

`endif
